/* logic/ao_periph_settings.svh */
// Widths and reset values for the always-on subsystem.
// The block select field sits above the 8-bit offset field.
`ifndef AO_PERIPH_SETTINGS_SVH
`define AO_PERIPH_SETTINGS_SVH

// External byte address and data word
`define AO_ADDR_W 12
`define AO_DATA_W 32

// Block select field, bits below AO_BLK_LSB form the offset
`define AO_BLK_MSB 11
`define AO_BLK_LSB 8

// Read value for an undecoded block
`define AO_ERR_DATA 32'hBADC_AB1E

// Scratch register after reset
`define AO_SCRATCH_RST 32'h5A5A_0000

`endif

/* logic/ao_periph_pkg.sv */
// Types shared by the always-on subsystem and its testbench.
// Field widths follow the settings header.
`include "ao_periph_settings.svh"

package ao_periph_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } reg_op_e;

  // Values above BLK_POWER are undecoded
  typedef enum logic [`AO_BLK_MSB-`AO_BLK_LSB:0] {
    BLK_SOC   = 4'd0,
    BLK_TIMER = 4'd1,
    BLK_POWER = 4'd2
  } ao_block_e;

  typedef enum logic [2:0] {
    PG_ON     = 3'd0,
    PG_ISO    = 3'd1,
    PG_RST    = 3'd2,
    PG_SW_OFF = 3'd3,
    PG_OFF    = 3'd4,
    PG_SW_ON  = 3'd5,
    PG_UNRST  = 3'd6,
    PG_UNISO  = 3'd7
  } pg_state_e;

  typedef struct packed {
    reg_op_e                op;
    logic [`AO_ADDR_W-1:0]  addr;
    logic [`AO_DATA_W-1:0]  wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`AO_DATA_W-1:0] rdata;
    logic                  err;
  } bus_rsp_t;

  typedef struct packed {
    logic                   valid;
    reg_op_e                op;
    logic [`AO_BLK_LSB-1:0] offset;
    logic [`AO_DATA_W-1:0]  wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`AO_DATA_W-1:0] rdata;
  } reg_rsp_t;

endpackage

/* logic/reg_bridge.sv */
// Four-phase slave to single-cycle register request, one port per block.
// bus_req_i must stay stable while req_i is high.
`timescale 1ns/1ps
`include "ao_periph_settings.svh"

module reg_bridge
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     req_i,
  input  bus_req_t bus_req_i,
  output logic     ack_o,
  output bus_rsp_t bus_rsp_o,
  output reg_req_t soc_req_o,
  output reg_req_t timer_req_o,
  output reg_req_t pwr_req_o,
  input  reg_rsp_t soc_rsp_i,
  input  reg_rsp_t timer_rsp_i,
  input  reg_rsp_t pwr_rsp_i
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_WAIT,
    PH_ACK
  } phase_e;

  phase_e    phase_q;
  bus_req_t  req_q;
  bus_rsp_t  rsp_q;
  bus_rsp_t  rsp_d;
  reg_req_t  req_base;
  ao_block_e blk;
  logic      in_wait;

  assign blk     = ao_block_e'(req_q.addr[`AO_BLK_MSB:`AO_BLK_LSB]);
  assign in_wait = (phase_q == PH_WAIT);

  assign req_base.valid  = 1'b0;
  assign req_base.op     = req_q.op;
  assign req_base.offset = req_q.addr[`AO_BLK_LSB-1:0];
  assign req_base.wdata  = req_q.wdata;

  // Valid goes only to the decoded block
  always_comb begin
    soc_req_o   = req_base;
    timer_req_o = req_base;
    pwr_req_o   = req_base;
    rsp_d.err   = 1'b0;
    case (blk)
      BLK_SOC: begin
        soc_req_o.valid = in_wait;
        rsp_d.rdata     = soc_rsp_i.rdata;
      end
      BLK_TIMER: begin
        timer_req_o.valid = in_wait;
        rsp_d.rdata       = timer_rsp_i.rdata;
      end
      BLK_POWER: begin
        pwr_req_o.valid = in_wait;
        rsp_d.rdata     = pwr_rsp_i.rdata;
      end
      default: begin
        rsp_d.rdata = `AO_ERR_DATA;
        rsp_d.err   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q <= PH_IDLE;
    end else begin
      case (phase_q)
        PH_IDLE: if (req_i) phase_q <= PH_WAIT;
        PH_WAIT: phase_q <= PH_ACK;
        PH_ACK:  if (!req_i) phase_q <= PH_IDLE;
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (phase_q == PH_IDLE && req_i) req_q <= bus_req_i;
    if (in_wait) rsp_q <= rsp_d;
  end

  assign ack_o     = (phase_q == PH_ACK);
  assign bus_rsp_o = rsp_q;

endmodule

/* logic/soc_ctrl_regs.sv */
// SoC control registers: boot select, scratch and exit.
// exit_valid_o stays set until reset once written.
`timescale 1ns/1ps
`include "ao_periph_settings.svh"

module soc_ctrl_regs
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic [`AO_DATA_W-1:0] scratch_q;
  logic                  wr;

  assign wr = reg_req_i.valid && (reg_req_i.op == OP_WRITE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scratch_q    <= `AO_SCRATCH_RST;
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (wr) begin
      case (reg_req_i.offset)
        8'h04: scratch_q <= reg_req_i.wdata;
        8'h08: begin
          exit_value_o <= reg_req_i.wdata;
          exit_valid_o <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      8'h00:   reg_rsp_o.rdata = {{(`AO_DATA_W-1){1'b0}}, boot_select_i};
      8'h04:   reg_rsp_o.rdata = scratch_q;
      8'h08:   reg_rsp_o.rdata = exit_value_o;
      default: reg_rsp_o.rdata = '0;
    endcase
  end

endmodule

/* logic/ao_timer.sv */
// Free-running compare timer with a sticky match flag.
// The flag sets only while counting; writing 1 to status bit 0 clears it.
`timescale 1ns/1ps
`include "ao_periph_settings.svh"

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_intr_o
);

  logic [`AO_DATA_W-1:0] count_q;
  logic [`AO_DATA_W-1:0] compare_q;
  logic                  cnt_en_q;
  logic                  intr_en_q;
  logic                  flag_q;
  logic                  wr;
  logic                  match;

  assign wr    = reg_req_i.valid && (reg_req_i.op == OP_WRITE);
  assign match = cnt_en_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      compare_q <= '0;
      cnt_en_q  <= 1'b0;
      intr_en_q <= 1'b0;
      flag_q    <= 1'b0;
    end else begin
      // Wraps at full width
      if (cnt_en_q) count_q <= count_q + 1'b1;
      if (wr) begin
        case (reg_req_i.offset)
          8'h00: count_q <= reg_req_i.wdata;
          8'h04: compare_q <= reg_req_i.wdata;
          8'h08: {intr_en_q, cnt_en_q} <= reg_req_i.wdata[1:0];
          8'h0C: if (reg_req_i.wdata[0]) flag_q <= 1'b0;
          default: ;
        endcase
      end
      // A new match wins over a clear in the same cycle
      if (match) flag_q <= 1'b1;
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.offset)
      8'h00:   reg_rsp_o.rdata = count_q;
      8'h04:   reg_rsp_o.rdata = compare_q;
      8'h08:   reg_rsp_o.rdata[1:0] = {intr_en_q, cnt_en_q};
      8'h0C:   reg_rsp_o.rdata[0] = flag_q;
      default: ;
    endcase
  end

  assign timer_intr_o = flag_q && intr_en_q;

endmodule

/* logic/power_gate_fsm.sv */
// Power sequencer for one switchable domain.
// Goes down on core sleep when armed, comes back on any wake interrupt.
// Switch acknowledge is a four-phase handshake with variable latency.
`timescale 1ns/1ps
`include "ao_periph_settings.svh"

module power_gate_fsm
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     core_sleep_i,
  input  logic     intr_i,
  input  logic     timer_intr_i,
  output logic     pg_switch_o,
  input  logic     pg_switch_ack_i,
  output logic     iso_o,
  output logic     rst_no
);

  pg_state_e             state_q;
  pg_state_e             state_d;
  logic                  arm_q;
  logic [`AO_DATA_W-1:0] pd_count_q;
  logic                  wr;
  logic                  pd_done;

  assign wr      = reg_req_i.valid && (reg_req_i.op == OP_WRITE);
  assign pd_done = (state_q == PG_SW_OFF) && (state_d == PG_OFF);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PG_ON:     if (arm_q && core_sleep_i) state_d = PG_ISO;
      PG_ISO:    state_d = PG_RST;
      PG_RST:    state_d = PG_SW_OFF;
      // Wait for the switch to report off
      PG_SW_OFF: if (!pg_switch_ack_i) state_d = PG_OFF;
      PG_OFF:    if (timer_intr_i || intr_i) state_d = PG_SW_ON;
      PG_SW_ON:  if (pg_switch_ack_i) state_d = PG_UNRST;
      PG_UNRST:  state_d = PG_UNISO;
      PG_UNISO:  state_d = PG_ON;
      default:   state_d = PG_ON;
    endcase
  end

  // Outputs decoded from the next state so they line up with state_q
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= PG_ON;
      iso_o       <= 1'b0;
      rst_no      <= 1'b1;
      pg_switch_o <= 1'b1;
    end else begin
      state_q     <= state_d;
      iso_o       <= !(state_d inside {PG_ON, PG_UNISO});
      rst_no      <= !(state_d inside {PG_RST, PG_SW_OFF, PG_OFF, PG_SW_ON});
      pg_switch_o <= !(state_d inside {PG_SW_OFF, PG_OFF});
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      arm_q      <= 1'b0;
      pd_count_q <= '0;
    end else begin
      if (pd_done) pd_count_q <= pd_count_q + 1'b1;
      if (wr) begin
        case (reg_req_i.offset)
          8'h00: arm_q <= reg_req_i.wdata[0];
          // Clear takes priority over a completing power-down
          8'h08: pd_count_q <= '0;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.offset)
      8'h00:   reg_rsp_o.rdata[0] = arm_q;
      8'h04:   reg_rsp_o.rdata[2:0] = state_q;
      8'h08:   reg_rsp_o.rdata = pd_count_q;
      default: ;
    endcase
  end

endmodule

/* logic/ao_peripheral_subsystem.sv */
// Always-on peripheral subsystem top: bridge plus three register blocks.
// Single clock; the timer interrupt also wakes the power domain.
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  // External register port
  input  logic        req_i,
  input  bus_req_t    bus_req_i,
  output logic        ack_o,
  output bus_rsp_t    bus_rsp_o,

  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,

  // Power domain control
  input  logic        core_sleep_i,
  input  logic        intr_i,
  output logic        pg_switch_o,
  input  logic        pg_switch_ack_i,
  output logic        iso_o,
  output logic        rst_no,

  output logic        timer_intr_o
);

  reg_req_t soc_req;
  reg_req_t timer_req;
  reg_req_t pwr_req;
  reg_rsp_t soc_rsp;
  reg_rsp_t timer_rsp;
  reg_rsp_t pwr_rsp;

  reg_bridge u_reg_bridge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .bus_req_i   (bus_req_i),
    .ack_o       (ack_o),
    .bus_rsp_o   (bus_rsp_o),
    .soc_req_o   (soc_req),
    .timer_req_o (timer_req),
    .pwr_req_o   (pwr_req),
    .soc_rsp_i   (soc_rsp),
    .timer_rsp_i (timer_rsp),
    .pwr_rsp_i   (pwr_rsp)
  );

  soc_ctrl_regs u_soc_ctrl_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .reg_req_i     (soc_req),
    .reg_rsp_o     (soc_rsp),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  ao_timer u_ao_timer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .reg_req_i    (timer_req),
    .reg_rsp_o    (timer_rsp),
    .timer_intr_o (timer_intr_o)
  );

  power_gate_fsm u_power_gate_fsm (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .reg_req_i       (pwr_req),
    .reg_rsp_o       (pwr_rsp),
    .core_sleep_i    (core_sleep_i),
    .intr_i          (intr_i),
    .timer_intr_i    (timer_intr_o),
    .pg_switch_o     (pg_switch_o),
    .pg_switch_ack_i (pg_switch_ack_i),
    .iso_o           (iso_o),
    .rst_no          (rst_no)
  );

endmodule

/* verif/ao_periph_assert.sv */
// Protocol and power sequencing properties, bound into the subsystem top.
// Checks are disabled while reset_i is high.
`timescale 1ns/1ps

module ao_periph_assert
  import ao_periph_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     req_i,
  input logic     ack_i,
  input bus_rsp_t bus_rsp_i,
  input logic     pg_switch_i,
  input logic     iso_i,
  input logic     rst_ni
);

  // Four-phase slave only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_i) |-> req_i)
    else $error("ack_o rose while req_i was low");

  switch_off_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(pg_switch_i) |-> iso_i)
    else $error("pg_switch_o fell while iso_o was low");

  iso_release_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(iso_i) |-> rst_ni)
    else $error("iso_o fell while rst_no was low");

  // Response must hold for the whole ack phase
  rsp_stable_during_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_i && $past(ack_i)) |-> $stable(bus_rsp_i))
    else $error("bus_rsp_o changed while ack_o was high");

endmodule

bind ao_peripheral_subsystem ao_periph_assert u_ao_periph_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_i       (req_i),
  .ack_i       (ack_o),
  .bus_rsp_i   (bus_rsp_o),
  .pg_switch_i (pg_switch_o),
  .iso_i       (iso_o),
  .rst_ni      (rst_no)
);

/* verif/ao_periph_tb.sv */
// Random register traffic against a reference model, plus timer and power cycle checks.
// Power switch acknowledge follows pg_switch_o after 1 to 8 cycles.
`timescale 1ns/1ps
`include "ao_periph_settings.svh"

module ao_periph_tb
  import ao_periph_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_SCRATCH = 50;
  localparam int NUM_DECODE  = 8;
  localparam int NUM_PWR     = 3;
  localparam int NUM_MIXED   = 100;
  localparam int PLANNED     = NUM_SCRATCH * 3 + 3 + NUM_DECODE * 3 + 10 + NUM_PWR * 16 + 2
                               + NUM_MIXED;
  localparam int WATCHDOG_CYCLES = 200 * PLANNED + 2000;
  localparam int HS_LIMIT    = 50;
  // Req sampled at the next edge and ack one edge later
  localparam int ACK_NEGEDGES = 3;

  logic        clk_i;
  logic        reset_i;
  logic        req_i;
  bus_req_t    bus_req_i;
  logic        ack_o;
  bus_rsp_t    bus_rsp_o;
  logic        boot_select_i;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        core_sleep_i;
  logic        intr_i;
  logic        pg_switch_o;
  logic        pg_switch_ack_i;
  logic        iso_o;
  logic        rst_no;
  logic        timer_intr_o;

  // Reference model
  logic [31:0] m_scratch;
  logic [31:0] m_exit;
  logic [31:0] m_count;
  logic [31:0] m_compare;
  logic [1:0]  m_ctrl;
  logic        m_arm;
  logic [31:0] m_pd_count;

  logic [31:0] rng_state;
  logic [31:0] sw_state;
  logic        sw_model_on;
  logic        pwr_watch;
  logic        iso_prev;
  logic        rst_prev;
  logic        sw_prev;
  time         ack_time;
  time         t_iso_up;
  time         t_rst_down;
  time         t_sw_off;
  time         t_sw_on;
  time         t_rst_up;
  time         t_iso_down;

  ao_peripheral_subsystem u_ao_peripheral_subsystem (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_i           (req_i),
    .bus_req_i       (bus_req_i),
    .ack_o           (ack_o),
    .bus_rsp_o       (bus_rsp_o),
    .boot_select_i   (boot_select_i),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o),
    .core_sleep_i    (core_sleep_i),
    .intr_i          (intr_i),
    .pg_switch_o     (pg_switch_o),
    .pg_switch_ack_i (pg_switch_ack_i),
    .iso_o           (iso_o),
    .rst_no          (rst_no),
    .timer_intr_o    (timer_intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] rand16();
    rng_state = lcg_next(rng_state);
    return rng_state[31:16];
  endfunction

  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    hi = rand16();
    return {hi, rand16()};
  endfunction

  function automatic logic [11:0] addr_of(input ao_block_e blk, input logic [7:0] off);
    return {blk, off};
  endfunction

  function automatic logic [31:0] timer_model(input logic [7:0] off);
    case (off)
      8'h00:   return m_count;
      8'h04:   return m_compare;
      8'h08:   return {30'b0, m_ctrl};
      default: return 32'b0;
    endcase
  endfunction

  function automatic logic [31:0] pwr_model(input logic [7:0] off);
    case (off)
      8'h00:   return {31'b0, m_arm};
      8'h04:   return {29'b0, PG_ON};
      default: return m_pd_count;
    endcase
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      report_failure($sformatf("Error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
  endtask

  // One four-phase access with req_i held for hold extra cycles
  task automatic bus_access(input reg_op_e op, input logic [11:0] addr,
                            input logic [31:0] wdata, input int hold, output bus_rsp_t rsp);
    int waited;
    @(posedge clk_i);
    #1;
    bus_req_i.op    = op;
    bus_req_i.addr  = addr;
    bus_req_i.wdata = wdata;
    req_i           = 1'b1;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > HS_LIMIT) report_failure("Timeout: ack_o never rose for a request");
    end while (!ack_o);
    check_eq(waited, ACK_NEGEDGES, "ack latency");
    ack_time = $time;
    rsp = bus_rsp_o;
    repeat (hold) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > HS_LIMIT) report_failure("Timeout: ack_o stayed high after req_i fell");
    end while (ack_o);
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input int hold);
    bus_rsp_t rsp;
    bus_access(OP_WRITE, addr, data, hold, rsp);
    check_eq(rsp.err, 1'b0, "error flag on write");
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    bus_rsp_t rsp;
    bus_access(OP_READ, addr, 32'b0, 0, rsp);
    check_eq(rsp.err, 1'b0, "error flag on read");
    data = rsp.rdata;
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp, input int hold,
                            input string what);
    bus_rsp_t rsp;
    bus_access(OP_READ, addr, 32'b0, hold, rsp);
    check_eq(rsp.err, 1'b0, "error flag on read");
    check_eq(rsp.rdata, exp, what);
  endtask

  task automatic wait_pg_state(input pg_state_e target);
    logic [31:0] rd;
    int polls;
    polls = 0;
    do begin
      read_reg(addr_of(BLK_POWER, 8'h04), rd);
      polls++;
      if (polls > 40) report_failure($sformatf("Power manager never reached %s", target.name()));
    end while (rd[2:0] != target);
  endtask

  // Switch model acknowledges after a random delay
  initial begin
    int delay;
    wait (sw_model_on);
    forever begin
      @(negedge clk_i);
      if (pg_switch_o !== pg_switch_ack_i) begin
        sw_state = lcg_next(sw_state);
        delay = 1 + sw_state[31:16] % 8;
        repeat (delay) @(posedge clk_i);
        #1 pg_switch_ack_i = pg_switch_o;
      end
    end
  end

  // Edge times of the power domain controls
  always @(negedge clk_i) begin
    if (pwr_watch) begin
      if (iso_o && !iso_prev) t_iso_up = $time;
      if (!rst_no && rst_prev) t_rst_down = $time;
      if (!pg_switch_o && sw_prev) t_sw_off = $time;
      if (pg_switch_o && !sw_prev) t_sw_on = $time;
      if (rst_no && !rst_prev) t_rst_up = $time;
      if (!iso_o && iso_prev) t_iso_down = $time;
    end
    iso_prev = iso_o;
    rst_prev = rst_no;
    sw_prev  = pg_switch_o;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    report_failure("Watchdog expired before all tests finished");
  end

  initial begin
    logic [31:0] data;
    logic [3:0]  sel;
    logic [7:0]  off;
    bus_rsp_t    rsp;
    int          cmp;
    int          cycles;
    int          hold;
    int          pick;
    rng_state       = 32'd12900;
    sw_state        = lcg_next(32'd12900);
    reset_i         = 1'b1;
    req_i           = 1'b0;
    bus_req_i       = '0;
    boot_select_i   = 1'b0;
    core_sleep_i    = 1'b0;
    intr_i          = 1'b0;
    pg_switch_ack_i = 1'b1;
    sw_model_on     = 1'b0;
    pwr_watch       = 1'b0;
    m_scratch       = `AO_SCRATCH_RST;
    m_exit          = 32'b0;
    m_count         = 32'b0;
    m_compare       = 32'b0;
    m_ctrl          = 2'b0;
    m_arm           = 1'b0;
    m_pd_count      = 32'b0;
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    check_eq({ack_o, exit_valid_o, timer_intr_o}, 3'b000, "ack, exit valid, intr after reset");
    check_eq({pg_switch_o, iso_o, rst_no}, 3'b101, "power controls after reset");
    sw_model_on = 1'b1;
    read_check(addr_of(BLK_SOC, 8'h04), m_scratch, 0, "scratch reset value");

    // Scratch round trip and boot select
    for (int i = 0; i < NUM_SCRATCH; i++) begin
      data = rand32();
      write_reg(addr_of(BLK_SOC, 8'h04), data, 0);
      m_scratch = data;
      read_check(addr_of(BLK_SOC, 8'h04), m_scratch, 0, "scratch read-back");
      data = rand32();
      @(posedge clk_i);
      #1 boot_select_i = data[0];
      read_check(addr_of(BLK_SOC, 8'h00), {31'b0, data[0]}, 0, "boot select");
    end

    // Exit register
    check_eq(exit_valid_o, 1'b0, "exit valid before write");
    data = rand32();
    write_reg(addr_of(BLK_SOC, 8'h08), data, 0);
    m_exit = data;
    check_eq(exit_valid_o, 1'b1, "exit valid after write");
    check_eq(exit_value_o, m_exit, "exit value");
    read_check(addr_of(BLK_SOC, 8'h08), m_exit, 0, "exit read-back");

    // Undecoded block selects
    for (int i = 0; i < NUM_DECODE; i++) begin
      sel = 4'd3 + 4'(rand16() % 13);
      off = (i % 2 == 0) ? 8'h04 : 8'(rand16());
      bus_access(OP_READ, {sel, off}, 32'b0, 0, rsp);
      check_eq(rsp.err, 1'b1, "undecoded read error flag");
      check_eq(rsp.rdata, `AO_ERR_DATA, "undecoded read data");
      bus_access(OP_WRITE, {sel, off}, rand32(), 0, rsp);
      check_eq(rsp.err, 1'b1, "undecoded write error flag");
      check_eq(rsp.rdata, `AO_ERR_DATA, "undecoded write data");
      read_check(addr_of(BLK_SOC, 8'h04), m_scratch, 0, "scratch after undecoded access");
    end

    // Timer compare and interrupt
    check_eq(timer_intr_o, 1'b0, "timer interrupt before test");
    cmp = 5 + rand16() % 56;
    write_reg(addr_of(BLK_TIMER, 8'h00), 32'b0, 0);
    write_reg(addr_of(BLK_TIMER, 8'h04), cmp, 0);
    write_reg(addr_of(BLK_TIMER, 8'h08), 32'h3, 0);
    cycles = 0;
    while (!timer_intr_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 200) report_failure("Timeout: timer_intr_o never rose");
    end
    check_eq(($time - ack_time) / CLK_PERIOD, cmp + 1, "cycles from enable to interrupt");
    read_check(addr_of(BLK_TIMER, 8'h0C), 32'h1, 0, "timer status set");
    write_reg(addr_of(BLK_TIMER, 8'h0C), 32'h1, 0);
    read_check(addr_of(BLK_TIMER, 8'h0C), 32'h0, 0, "timer status cleared");
    check_eq(timer_intr_o, 1'b0, "timer interrupt after clear");
    write_reg(addr_of(BLK_TIMER, 8'h08), 32'h0, 0);
    write_reg(addr_of(BLK_TIMER, 8'h00), 32'h0, 0);
    m_ctrl    = 2'b0;
    m_count   = 32'b0;
    m_compare = cmp;

    // Power cycles
    write_reg(addr_of(BLK_POWER, 8'h00), 32'h1, 0);
    m_arm = 1'b1;
    for (int c = 0; c < NUM_PWR; c++) begin
      t_iso_up   = 0;
      t_rst_down = 0;
      t_sw_off   = 0;
      t_sw_on    = 0;
      t_rst_up   = 0;
      t_iso_down = 0;
      @(posedge clk_i);
      #1;
      pwr_watch    = 1'b1;
      core_sleep_i = 1'b1;
      wait_pg_state(PG_OFF);
      @(posedge clk_i);
      #1 core_sleep_i = 1'b0;
      check_eq({pg_switch_o, iso_o, rst_no}, 3'b010, "power controls in PG_OFF");
      @(posedge clk_i);
      #1 intr_i = 1'b1;
      @(posedge clk_i);
      #1 intr_i = 1'b0;
      wait_pg_state(PG_ON);
      @(negedge clk_i);
      pwr_watch = 1'b0;
      check_eq(t_iso_up > 0, 1'b1, "isolation raised on power-down");
      check_eq(t_iso_up < t_rst_down, 1'b1, "reset asserted after isolation");
      check_eq(t_rst_down < t_sw_off, 1'b1, "switch off after reset");
      check_eq(t_sw_off < t_sw_on, 1'b1, "switch on after switch off");
      check_eq(t_sw_on < t_rst_up, 1'b1, "reset released after switch on");
      check_eq(t_rst_up < t_iso_down, 1'b1, "isolation dropped after reset release");
      m_pd_count++;
    end
    read_check(addr_of(BLK_POWER, 8'h08), m_pd_count, 0, "power-down count");

    // Mixed traffic with random hold lengths
    for (int i = 0; i < NUM_MIXED; i++) begin
      hold = rand16() % 6;
      pick = rand16() % 12;
      data = rand32();
      case (pick)
        0: begin
          @(posedge clk_i);
          #1 boot_select_i = data[0];
          read_check(addr_of(BLK_SOC, 8'h00), {31'b0, data[0]}, hold, "boot select");
        end
        1: begin
          write_reg(addr_of(BLK_SOC, 8'h04), data, hold);
          m_scratch = data;
        end
        2: read_check(addr_of(BLK_SOC, 8'h04), m_scratch, hold, "scratch");
        3: begin
          write_reg(addr_of(BLK_SOC, 8'h08), data, hold);
          m_exit = data;
        end
        4: read_check(addr_of(BLK_SOC, 8'h08), m_exit, hold, "exit value");
        5: begin
          write_reg(addr_of(BLK_TIMER, 8'h00), data, hold);
          m_count = data;
        end
        6: begin
          write_reg(addr_of(BLK_TIMER, 8'h04), data, hold);
          m_compare = data;
        end
        7: begin
          off = {4'h0, data[1:0], 2'b00};
          read_check(addr_of(BLK_TIMER, off), timer_model(off), hold, "timer register");
        end
        8: begin
          // Counting stays off so the count is predictable
          write_reg(addr_of(BLK_TIMER, 8'h08), data & 32'hFFFF_FFFE, hold);
          m_ctrl = {data[1], 1'b0};
        end
        9: begin
          write_reg(addr_of(BLK_POWER, 8'h00), data, hold);
          m_arm = data[0];
        end
        10: begin
          off = 8'(4 * (data % 3));
          read_check(addr_of(BLK_POWER, off), pwr_model(off), hold, "power register");
        end
        default: begin
          write_reg(addr_of(BLK_POWER, 8'h08), data, hold);
          m_pd_count = 32'b0;
        end
      endcase
    end

    @(posedge clk_i);
    $display("All tests passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/ao_periph_pkg.sv
logic/reg_bridge.sv
logic/soc_ctrl_regs.sv
logic/ao_timer.sv
logic/power_gate_fsm.sv
logic/ao_peripheral_subsystem.sv
verif/ao_periph_assert.sv
verif/ao_periph_tb.sv

/* Bender.yml */
package:
  name: ao_periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/ao_periph_pkg.sv
      - logic/reg_bridge.sv
      - logic/soc_ctrl_regs.sv
      - logic/ao_timer.sv
      - logic/power_gate_fsm.sv
      - logic/ao_peripheral_subsystem.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verif/ao_periph_assert.sv
      - verif/ao_periph_tb.sv
